//--- build.f
+incdir+.
mips_isa_pkg.sv
mips_core_pkg.sv
mips_fetch.sv
mips_control.sv
mips_regfile.sv
mips_execute.sv
mips_data_mem.sv
mips_core.sv
mips_core_checker.sv
mips_core_tb.sv

//--- mips_core_tb.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_core_tb
	import mips_isa_pkg::*;
	import mips_core_pkg::*;
();

	localparam int          ROM_WORDS = 64;
	localparam logic [31:0] SEED      = 32'hadedc328;

	logic     clk;
	logic     arst_n;
	addr_t    imem_addr;
	word_t    imem_rdata;
	logic     wb_en;
	reg_idx_t wb_idx;
	word_t    wb_data;
	int       pending;

	// Program table, one row per instruction word
	word_t    prog_tab [ROM_WORDS];
	logic     wr_tab   [ROM_WORDS];
	reg_idx_t idx_tab  [ROM_WORDS];
	word_t    data_tab [ROM_WORDS];
	int       n_rows;
	word_t    rom      [ROM_WORDS];
	addr_t    prog_end;
	int       cycle_count;
	int       cycle_limit;
	int       errors;

	mips_core i_mips_core (
		.clk        (clk),
		.arst_n     (arst_n),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.wb_en      (wb_en),
		.wb_idx     (wb_idx),
		.wb_data    (wb_data)
	);

	mips_core_checker i_checker (
		.clk       (clk),
		.arst_n    (arst_n),
		.imem_addr (imem_addr),
		.prog_end  (prog_end),
		.wb_en     (wb_en),
		.wb_idx    (wb_idx),
		.wb_data   (wb_data),
		.pending   (pending)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ---------------------------------------------------------------------------
	// Instruction encoding
	// ---------------------------------------------------------------------------
	function automatic word_t rtype_word(funct_t fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t itype_word(opcode_t op, reg_idx_t rt, reg_idx_t rs,
			logic [15:0] imm16);
		return {op, rs, rt, imm16};
	endfunction

	function automatic word_t jump_word(int slot);
		addr_t target;
		target = `MIPS_RESET_PC + 4 * slot;
		return {OP_J, target[27:2]};
	endfunction

	task automatic add_row(word_t instr, logic wr, reg_idx_t idx, word_t data);
		prog_tab[n_rows] = instr;
		wr_tab[n_rows]   = wr;
		idx_tab[n_rows]  = idx;
		data_tab[n_rows] = data;
		n_rows++;
	endtask

	task automatic build_program();
		add_row(itype_word(OP_ADDI, 1, 0, 16'h0f0f), 1, 1, 32'h0000_0f0f);  // Slot 0
		add_row(itype_word(OP_ADDI, 2, 0, 16'hfffd), 1, 2, 32'hffff_fffd);
		add_row(rtype_word(FN_ADD, 3, 1, 2), 1, 3, 32'h0000_0f0c);  // r1 from W, r2 from M
		add_row(rtype_word(FN_SUB, 4, 1, 2), 1, 4, 32'h0000_0f12);  // r1 write-through
		add_row(rtype_word(FN_AND, 5, 3, 4), 1, 5, 32'h0000_0f00);
		add_row(rtype_word(FN_OR, 6, 3, 4), 1, 6, 32'h0000_0f1e);
		add_row(rtype_word(FN_SLT, 7, 2, 1), 1, 7, 32'h0000_0001);  // -3 < 3855 signed
		add_row(rtype_word(FN_SLT, 8, 1, 2), 1, 8, 32'h0000_0000);
		add_row(itype_word(OP_ADDI, 0, 0, 16'h0007), 0, 0, 0);      // r0 stays silent
		add_row(rtype_word(FN_ADD, 9, 0, 1), 1, 9, 32'h0000_0f0f);
		add_row(itype_word(OP_ADDI, 10, 0, 16'h0040), 1, 10, 32'h0000_0040);  // Slot 10
		add_row(itype_word(OP_SW, 6, 10, 16'h0004), 0, 0, 0);
		add_row(itype_word(OP_LW, 11, 10, 16'h0004), 1, 11, 32'h0000_0f1e);
		add_row(itype_word(OP_ADDI, 12, 0, 16'h0001), 1, 12, 32'h0000_0001);  // Load gap
		add_row(rtype_word(FN_ADD, 13, 11, 12), 1, 13, 32'h0000_0f1f);
		add_row(itype_word(OP_BEQ, 2, 1, 16'h0002), 0, 0, 0);       // Not taken
		add_row(itype_word(OP_ADDI, 14, 0, 16'h0011), 1, 14, 32'h0000_0011);
		add_row(itype_word(OP_ADDI, 15, 0, 16'h0022), 1, 15, 32'h0000_0022);
		add_row(itype_word(OP_BEQ, 14, 14, 16'h0002), 0, 0, 0);     // Taken to slot 21
		add_row(itype_word(OP_ADDI, 16, 0, 16'h0033), 0, 0, 0);     // Squashed
		add_row(itype_word(OP_ADDI, 17, 0, 16'h0044), 0, 0, 0);     // Slot 20 is squashed
		add_row(itype_word(OP_ADDI, 18, 0, 16'h0055), 1, 18, 32'h0000_0055);
		add_row(jump_word(25), 0, 0, 0);
		add_row(itype_word(OP_ADDI, 19, 0, 16'h0066), 0, 0, 0);     // Squashed behind j
		add_row(itype_word(OP_ADDI, 20, 0, 16'h0077), 0, 0, 0);     // Jumped over
		add_row(itype_word(OP_ADDI, 21, 0, 16'h0088), 1, 21, 32'h0000_0088);  // Slot 25
		add_row(rtype_word(FN_ADD, 22, 21, 18), 1, 22, 32'h0000_00dd);
		add_row(jump_word(27), 0, 0, 0);                            // Park here
		add_row(32'h0000_0000, 0, 0, 0);                            // Nop behind the loop
	endtask

	// Synchronous ROM that returns a nop outside the image
	function automatic word_t rom_word(addr_t addr);
		addr_t offset;
		offset = addr - `MIPS_RESET_PC;
		if (offset < 4 * ROM_WORDS) begin
			return rom[offset[31:2]];
		end
		return 32'h0;
	endfunction

	always @(posedge clk) begin
		imem_rdata <= rom_word(imem_addr);
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("run stopped after %0d cycles, %0d writebacks outstanding",
				cycle_count, pending);
			i_checker.report(errors);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		arst_n      = 1'b0;
		imem_rdata  = '0;
		cycle_count = 0;
		n_rows      = 0;
		void'($urandom(SEED));
		build_program();
		for (int i = 0; i < ROM_WORDS; i++) begin
			if (i < n_rows) begin
				rom[i] = prog_tab[i];
				if (wr_tab[i]) begin
					i_checker.expect_write(idx_tab[i], data_tab[i]);
				end
			end else begin
				rom[i] = $urandom;  // Never fetched
			end
		end
		prog_end    = `MIPS_RESET_PC + 4 * n_rows;
		cycle_limit = 5 * n_rows + 20;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		while (pending != 0) begin
			@(posedge clk);
		end
		repeat (10) @(posedge clk);  // Window for stray writes
		i_checker.report(errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- mips_core_checker.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_core_checker import mips_core_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  addr_t    imem_addr,
	input  addr_t    prog_end,   // First byte address past the program
	input  logic     wb_en,
	input  reg_idx_t wb_idx,
	input  word_t    wb_data,
	output int       pending
);

	reg_idx_t exp_idx_q [$];
	word_t    exp_data_q [$];
	int       checked_count;
	int       error_count;

	initial begin
		checked_count = 0;
		error_count   = 0;
	end

	// Expected writebacks arrive in program order
	task automatic expect_write(input reg_idx_t idx, input word_t data);
		exp_idx_q.push_back(idx);
		exp_data_q.push_back(data);
		pending = exp_idx_q.size();
	endtask

	task automatic check_write();
		reg_idx_t idx;
		word_t    data;
		if (exp_idx_q.size() == 0) begin
			$display("unexpected extra write of r%0d with %h", wb_idx, wb_data);
			error_count++;
		end else begin
			idx     = exp_idx_q.pop_front();
			data    = exp_data_q.pop_front();
			pending = exp_idx_q.size();
			checked_count++;
			if (wb_idx !== idx) begin
				$display("[FAIL] wb_idx got %h expected %h", wb_idx, idx);
				error_count++;
			end
			if (wb_data !== data) begin
				$display("[FAIL] wb_data got %h expected %h (r%0d)", wb_data, data, idx);
				error_count++;
			end
		end
	endtask

	// ---------------------------------------------------------------------------
	// Sampled mid-cycle away from the rising edge
	// ---------------------------------------------------------------------------
	always @(negedge clk) begin
		if (arst_n) begin
			if (imem_addr < `MIPS_RESET_PC || imem_addr >= prog_end) begin
				$display("fetch address %h lies outside the program", imem_addr);
				error_count++;
			end
			if (wb_en) begin
				check_write();
			end
		end
	end

	// Leftover entries are writes that never happened
	task automatic report(output int errors);
		while (exp_idx_q.size() != 0) begin
			$display("missing write of r%0d with %h", exp_idx_q[0], exp_data_q[0]);
			void'(exp_idx_q.pop_front());
			void'(exp_data_q.pop_front());
			error_count++;
		end
		pending = 0;
		$display("summary %0d writebacks checked, %0d errors", checked_count, error_count);
		errors = error_count;
	endtask

endmodule

//--- mips_core.sv
`timescale 1ns/1ps

module mips_core
	import mips_isa_pkg::*;
	import mips_core_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	output addr_t    imem_addr,
	input  word_t    imem_rdata,
	output logic     wb_en,
	output reg_idx_t wb_idx,
	output word_t    wb_data
);

	// Redirects
	logic     jump;
	addr_t    jump_target;
	logic     branch_taken;

	// Decode outputs
	reg_idx_t rs_idx;
	reg_idx_t rt_idx;
	word_t    imm;
	word_t    rs_data;
	word_t    rt_data;

	// Execute controls
	alu_op_t  alu_op;
	logic     alu_src_imm;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;
	logic     zero;

	// Memory stage
	logic     mem_we;
	logic     wb_from_mem;
	word_t    alu_result_m;
	word_t    store_data_m;
	word_t    mem_fwd_data;

	// ---------------------------------------------------------------------------
	// Fetch
	// ---------------------------------------------------------------------------
	mips_fetch i_fetch (
		.clk          (clk),
		.arst_n       (arst_n),
		.jump         (jump),
		.jump_target  (jump_target),
		.branch_taken (branch_taken),
		.branch_imm   (imm),
		.pc           (imem_addr),
		.pc_plus4_x   ()            // Return address, no link instruction here
	);

	// ---------------------------------------------------------------------------
	// Control and hazards
	// ---------------------------------------------------------------------------
	mips_control i_control (
		.clk          (clk),
		.arst_n       (arst_n),
		.instr        (imem_rdata),
		.zero         (zero),
		.rs_idx       (rs_idx),
		.rt_idx       (rt_idx),
		.imm          (imm),
		.alu_op       (alu_op),
		.alu_src_imm  (alu_src_imm),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.mem_we       (mem_we),
		.branch_taken (branch_taken),
		.jump         (jump),
		.jump_target  (jump_target),
		.wb_from_mem  (wb_from_mem),
		.wb_en        (wb_en),
		.wb_idx       (wb_idx)
	);

	// ---------------------------------------------------------------------------
	// Datapath
	// ---------------------------------------------------------------------------
	mips_regfile i_regfile (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_idx_a  (rs_idx),
		.rd_idx_b  (rt_idx),
		.we        (wb_en),
		.wr_idx    (wb_idx),
		.wr_data   (wb_data),
		.rd_data_a (rs_data),
		.rd_data_b (rt_data)
	);

	mips_execute i_execute (
		.clk          (clk),
		.arst_n       (arst_n),
		.rs_data      (rs_data),
		.rt_data      (rt_data),
		.imm          (imm),
		.alu_op       (alu_op),
		.alu_src_imm  (alu_src_imm),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.mem_fwd_data (mem_fwd_data),
		.wb_fwd_data  (wb_data),
		.zero         (zero),
		.alu_result_m (alu_result_m),
		.store_data_m (store_data_m)
	);

	mips_data_mem i_data_mem (
		.clk          (clk),
		.arst_n       (arst_n),
		.we           (mem_we),
		.addr         (alu_result_m),
		.wdata        (store_data_m),
		.alu_result_m (alu_result_m),
		.wb_from_mem  (wb_from_mem),
		.mem_fwd_data (mem_fwd_data),
		.wb_data      (wb_data)
	);

endmodule

//--- mips_data_mem.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_data_mem (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    we,
	input  logic [`MIPS_DATA_W-1:0] addr,
	input  logic [`MIPS_DATA_W-1:0] wdata,
	input  logic [`MIPS_DATA_W-1:0] alu_result_m,
	input  logic                    wb_from_mem,
	output logic [`MIPS_DATA_W-1:0] mem_fwd_data,
	output logic [`MIPS_DATA_W-1:0] wb_data
);

	localparam int IDX_W = $clog2(`MIPS_DMEM_DEPTH);

	logic [`MIPS_DATA_W-1:0] ram [`MIPS_DMEM_DEPTH];
	logic [IDX_W-1:0]        word_idx;
	logic [`MIPS_DATA_W-1:0] rdata;

	assign word_idx = addr[IDX_W+1:2]; // Upper address bits wrap around
	assign rdata    = ram[word_idx];

	always_ff @(posedge clk) begin
		if (we) begin
			ram[word_idx] <= wdata;
		end
	end

	// M-stage result, load data or ALU value
	assign mem_fwd_data = wb_from_mem ? rdata : alu_result_m;

	// M/W register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_data <= '0;
		end else begin
			wb_data <= mem_fwd_data;
		end
	end

endmodule

//--- mips_execute.sv
`timescale 1ns/1ps

module mips_execute
	import mips_isa_pkg::*;
	import mips_core_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  word_t    rs_data,
	input  word_t    rt_data,
	input  word_t    imm,
	input  alu_op_t  alu_op,
	input  logic     alu_src_imm,
	input  fwd_sel_t fwd_a,
	input  fwd_sel_t fwd_b,
	input  word_t    mem_fwd_data,
	input  word_t    wb_fwd_data,
	output logic     zero,
	output word_t    alu_result_m,
	output word_t    store_data_m
);

	word_t rs_x;
	word_t rt_x;
	word_t imm_x;
	word_t op_a;
	word_t rt_fwd;   // rt after forwarding, also the store data
	word_t op_b;
	word_t alu_y;

	// D/X operand register
	always_ff @(posedge clk) begin
		rs_x  <= rs_data;
		rt_x  <= rt_data;
		imm_x <= imm;
	end

	// ---------------------------------------------------------------------------
	// Operand forwarding
	// ---------------------------------------------------------------------------
	function automatic word_t fwd_mux(
		input fwd_sel_t sel,
		input word_t    reg_val,
		input word_t    m_val,
		input word_t    w_val
	);
		case (sel)
			FWD_MEM: return m_val;
			FWD_WB:  return w_val;
			default: return reg_val;
		endcase
	endfunction

	assign op_a   = fwd_mux(fwd_a, rs_x, mem_fwd_data, wb_fwd_data);
	assign rt_fwd = fwd_mux(fwd_b, rt_x, mem_fwd_data, wb_fwd_data);
	assign op_b   = alu_src_imm ? imm_x : rt_fwd;

	// ---------------------------------------------------------------------------
	// ALU
	// ---------------------------------------------------------------------------
	always_comb begin
		case (alu_op)
			ALU_SUB: alu_y = op_a - op_b;
			ALU_AND: alu_y = op_a & op_b;
			ALU_OR:  alu_y = op_a | op_b;
			ALU_SLT: alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
			default: alu_y = op_a + op_b;
		endcase
	end

	assign zero = (alu_y == '0); // beq takes this with ALU_SUB

	// X/M data register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			alu_result_m <= '0;
			store_data_m <= '0;
		end else begin
			alu_result_m <= alu_y;
			store_data_m <= rt_fwd;
		end
	end

endmodule

//--- mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile import mips_core_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  reg_idx_t rd_idx_a,
	input  reg_idx_t rd_idx_b,
	input  logic     we,
	input  reg_idx_t wr_idx,
	input  word_t    wr_data,
	output word_t    rd_data_a,
	output word_t    rd_data_b
);

	word_t regs [32];

	// Entry 0 is cleared by reset and never written
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Same-cycle write is visible to the reader in D
	assign rd_data_a = (we && wr_idx != '0 && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
	assign rd_data_b = (we && wr_idx != '0 && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule

//--- mips_control.sv
`timescale 1ns/1ps

module mips_control
	import mips_isa_pkg::*;
	import mips_core_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  word_t    instr,
	input  logic     zero,
	output reg_idx_t rs_idx,
	output reg_idx_t rt_idx,
	output word_t    imm,
	output alu_op_t  alu_op,
	output logic     alu_src_imm,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b,
	output logic     mem_we,
	output logic     branch_taken,
	output logic     jump,
	output addr_t    jump_target,
	output logic     wb_from_mem,
	output logic     wb_en,
	output reg_idx_t wb_idx
);

	opcode_t  opcode;
	funct_t   funct;
	reg_idx_t rd_idx;
	logic     d_valid;      // Low after reset and for the slot behind a redirect

	// Decoded in D
	logic     reg_we_d;
	logic     mem_we_d;
	logic     mem_to_reg_d;
	logic     alu_src_imm_d;
	logic     beq_d;
	alu_op_t  alu_op_d;
	reg_idx_t dst_d;

	// X stage
	logic     x_valid;
	logic     x_reg_we;
	logic     x_mem_we;
	logic     x_mem_to_reg;
	logic     x_beq;
	reg_idx_t x_rs;
	reg_idx_t x_rt;
	reg_idx_t x_dst;

	// M stage
	logic     m_valid;
	logic     m_reg_we;
	logic     m_mem_we;
	logic     m_mem_to_reg;
	reg_idx_t m_dst;

	// W stage
	logic     w_valid;
	logic     w_reg_we;
	reg_idx_t w_dst;

	// ---------------------------------------------------------------------------
	// Decode
	// ---------------------------------------------------------------------------
	assign opcode      = instr[31:26];
	assign funct       = instr[5:0];
	assign rs_idx      = instr[25:21];
	assign rt_idx      = instr[20:16];
	assign rd_idx      = instr[15:11];
	assign imm         = {{16{instr[15]}}, instr[15:0]};
	assign jump_target = {4'h0, instr[25:0], 2'b00};

	always_comb begin
		reg_we_d      = 1'b0;
		mem_we_d      = 1'b0;
		mem_to_reg_d  = 1'b0;
		alu_src_imm_d = 1'b0;
		beq_d         = 1'b0;
		alu_op_d      = ALU_ADD;
		dst_d         = rt_idx;   // I-type default
		case (opcode)
			OP_RTYPE: begin
				dst_d    = rd_idx;
				reg_we_d = 1'b1;
				case (funct)
					FN_ADD:  alu_op_d = ALU_ADD;
					FN_SUB:  alu_op_d = ALU_SUB;
					FN_AND:  alu_op_d = ALU_AND;
					FN_OR:   alu_op_d = ALU_OR;
					FN_SLT:  alu_op_d = ALU_SLT;
					default: reg_we_d = 1'b0; // Unknown funct is a nop
				endcase
			end
			OP_ADDI: begin
				reg_we_d      = 1'b1;
				alu_src_imm_d = 1'b1;
			end
			OP_LW: begin
				reg_we_d      = 1'b1;
				alu_src_imm_d = 1'b1;
				mem_to_reg_d  = 1'b1;
			end
			OP_SW: begin
				mem_we_d      = 1'b1;
				alu_src_imm_d = 1'b1;
			end
			OP_BEQ: begin
				beq_d    = 1'b1;
				alu_op_d = ALU_SUB;
			end
			default: begin
			end
		endcase
		// r0 is never a destination, so nothing forwards from it either
		if (dst_d == '0) begin
			reg_we_d = 1'b0;
		end
	end

	// ---------------------------------------------------------------------------
	// Redirects
	// ---------------------------------------------------------------------------
	assign jump         = d_valid && (opcode == OP_J);
	assign branch_taken = x_valid && x_beq && zero;

	// ---------------------------------------------------------------------------
	// Stage control pipeline
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			d_valid      <= 1'b0;
			x_valid      <= 1'b0;
			x_reg_we     <= 1'b0;
			x_mem_we     <= 1'b0;
			x_mem_to_reg <= 1'b0;
			x_beq        <= 1'b0;
			x_rs         <= '0;
			x_rt         <= '0;
			x_dst        <= '0;
			alu_op       <= ALU_ADD;
			alu_src_imm  <= 1'b0;
			m_valid      <= 1'b0;
			m_reg_we     <= 1'b0;
			m_mem_we     <= 1'b0;
			m_mem_to_reg <= 1'b0;
			m_dst        <= '0;
			w_valid      <= 1'b0;
			w_reg_we     <= 1'b0;
			w_dst        <= '0;
		end else begin
			d_valid      <= !(jump || branch_taken);  // Squash the word fetched behind
			x_valid      <= d_valid && !branch_taken;
			x_reg_we     <= reg_we_d;
			x_mem_we     <= mem_we_d;
			x_mem_to_reg <= mem_to_reg_d;
			x_beq        <= beq_d;
			x_rs         <= rs_idx;
			x_rt         <= rt_idx;
			x_dst        <= dst_d;
			alu_op       <= alu_op_d;
			alu_src_imm  <= alu_src_imm_d;
			m_valid      <= x_valid;
			m_reg_we     <= x_reg_we;
			m_mem_we     <= x_mem_we;
			m_mem_to_reg <= x_mem_to_reg;
			m_dst        <= x_dst;
			w_valid      <= m_valid;
			w_reg_we     <= m_reg_we;
			w_dst        <= m_dst;
		end
	end

	assign mem_we      = m_valid && m_mem_we;
	assign wb_from_mem = m_mem_to_reg;
	assign wb_en       = w_valid && w_reg_we;
	assign wb_idx      = w_dst;

	// ---------------------------------------------------------------------------
	// Forwarding selects, youngest writer first
	// ---------------------------------------------------------------------------
	function automatic fwd_sel_t fwd_select(
		input reg_idx_t src,
		input logic     m_wr,
		input reg_idx_t m_idx,
		input logic     w_wr,
		input reg_idx_t w_idx
	);
		if (m_wr && m_idx == src) begin
			return FWD_MEM;
		end
		if (w_wr && w_idx == src) begin
			return FWD_WB;
		end
		return FWD_NONE;
	endfunction

	assign fwd_a = fwd_select(x_rs, m_valid && m_reg_we, m_dst, w_valid && w_reg_we, w_dst);
	assign fwd_b = fwd_select(x_rt, m_valid && m_reg_we, m_dst, w_valid && w_reg_we, w_dst);

endmodule

//--- mips_fetch.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_fetch import mips_core_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  jump,
	input  addr_t jump_target,
	input  logic  branch_taken,
	input  word_t branch_imm,
	output addr_t pc,
	output addr_t pc_plus4_x
);

	addr_t pc_plus4;
	addr_t pc_plus4_d;
	word_t imm_x;         // Sign-extended beq offset in X
	addr_t branch_target;
	addr_t pc_next;

	assign pc_plus4      = pc + 32'd4;
	assign branch_target = pc_plus4_x + {imm_x[29:0], 2'b00}; // Word offset to bytes

	// Branch in X is older than a jump in D
	always_comb begin
		if (branch_taken) begin
			pc_next = branch_target;
		end else if (jump) begin
			pc_next = jump_target;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= `MIPS_RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// Return address and offset follow the instruction to X
	always_ff @(posedge clk) begin
		pc_plus4_d <= pc_plus4;
		pc_plus4_x <= pc_plus4_d;
		imm_x      <= branch_imm;
	end

endmodule

//--- mips_core_pkg.sv
`include "mips_defines.svh"

package mips_core_pkg;

	// ---------------------------------------------------------------------------
	// Datapath vectors
	// ---------------------------------------------------------------------------
	typedef logic [`MIPS_DATA_W-1:0]     word_t;
	typedef logic [`MIPS_DATA_W-1:0]     addr_t;    // Byte address
	typedef logic [`MIPS_REG_ADDR_W-1:0] reg_idx_t;

	// ---------------------------------------------------------------------------
	// Operand source for the execute stage
	// ---------------------------------------------------------------------------
	typedef enum logic [1:0] {
		FWD_NONE, // Value read from the register file in D
		FWD_MEM,  // Result of the instruction now in M
		FWD_WB    // Result of the instruction now in W
	} fwd_sel_t;

endpackage

//--- mips_isa_pkg.sv
package mips_isa_pkg;

	typedef logic [5:0] opcode_t; // Instruction bits 31:26
	typedef logic [5:0] funct_t;  // Instruction bits 5:0 for R-type

	// Major opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_J     = 6'h02;
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_SW    = 6'h2b;

	// R-type function codes
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR  = 6'h25;
	localparam funct_t FN_SLT = 6'h2a;

	// ALU operations
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB, // Also used for the beq compare
		ALU_AND,
		ALU_OR,
		ALU_SLT  // Signed compare
	} alu_op_t;

endpackage

//--- mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// ---------------------------------------------------------------------------
// Core widths
// ---------------------------------------------------------------------------
`define MIPS_DATA_W     32
`define MIPS_REG_ADDR_W 5

// ---------------------------------------------------------------------------
// Memory map
// ---------------------------------------------------------------------------
`define MIPS_RESET_PC   32'h0040_0000 // Start of the text segment
`define MIPS_DMEM_DEPTH 256           // Data RAM size in words

`endif
